/* Makefile */
SIM  := obj_dir/Vda_tb
SRCS := $(shell cat all.f)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when the file list or a source changes.
$(SIM): all.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module da_tb -f all.f

run: $(SIM)
	$(SIM) > sim.log 2>&1 || true
	cat sim.log
	@if grep -qF '** FAIL **' sim.log; then \
		echo "Simulation reported failure"; \
		exit 1; \
	fi
	@if ! grep -qF '** PASS **' sim.log; then \
		echo "Simulation ended without a verdict"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

/* all.f */
rtl/da_pkg.sv
rtl/da_lut_bank.sv
rtl/da_regs_decode.sv
rtl/da_bit_serial.sv
rtl/da_result.sv
rtl/da_top.sv
testbench/tb_clock_gen.sv
testbench/da_tb.sv

/* rtl/da_bit_serial.sv */
module da_bit_serial (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic                                          start,
    input  logic [da_pkg::NUM_TAPS*da_pkg::SAMPLE_W-1:0]  samples,
    output logic                                          busy,
    output logic signed [da_pkg::ACC_W-1:0]               acc,
    output logic                                          acc_valid
);
    import da_pkg::*;

    logic [NUM_TAPS-1:0][SAMPLE_W-1:0]               samples_q;
    logic [BIT_CNT_W-1:0]                            bit_cnt;
    logic [NUM_TAPS-1:0]                             plane;
    logic signed [lut_val_w(LUT_TAPS)-1:0]           lo_value;
    logic signed [lut_val_w(NUM_TAPS-LUT_TAPS)-1:0]  hi_value;
    logic signed [ACC_W-1:0]                         plane_sum;
    logic signed [ACC_W-1:0]                         term;
    logic                                            msb_plane;

    // Bit k of every captured sample.
    always_comb begin
        for (int i = 0; i < NUM_TAPS; i++) begin
            plane[i] = samples_q[i][bit_cnt];
        end
    end

    da_lut_bank #(
        .base_tap (0),
        .taps     (LUT_TAPS)
    ) lut_lo (
        .sel   (plane[LUT_TAPS-1:0]),
        .value (lo_value)
    );

    da_lut_bank #(
        .base_tap (LUT_TAPS),
        .taps     (NUM_TAPS - LUT_TAPS)
    ) lut_hi (
        .sel   (plane[NUM_TAPS-1:LUT_TAPS]),
        .value (hi_value)
    );

    assign plane_sum = lo_value + hi_value;

    // The sign plane carries negative weight.
    assign msb_plane = (bit_cnt == BIT_CNT_W'(SAMPLE_W - 1));
    assign term = msb_plane ? -plane_sum : plane_sum;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
            acc_valid <= 1'b0;
            bit_cnt <= '0;
        end else begin
            acc_valid <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                bit_cnt <= BIT_CNT_W'(SAMPLE_W - 1);
            end else if (busy) begin
                if (bit_cnt == '0) begin
                    busy <= 1'b0;
                    acc_valid <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt - 1'b1;
                end
            end
        end
    end

    // Capture on start, then one plane per cycle.
    always_ff @(posedge clk) begin
        if (start) begin
            samples_q <= samples;
            acc <= '0;
        end else if (busy) begin
            acc <= (acc <<< 1) + term;
        end
    end

endmodule

/* rtl/da_lut_bank.sv */
module da_lut_bank #(
    parameter int base_tap = 0,
    parameter int taps = 4
) (
    input  logic [taps-1:0]                             sel,
    output logic signed [da_pkg::lut_val_w(taps)-1:0]   value
);
    import da_pkg::*;

    logic signed [lut_val_w(taps)-1:0] lut [2**taps];

    // One bit adds its coefficient, zero subtracts it.
    function automatic logic signed [lut_val_w(taps)-1:0] entry(logic [taps-1:0] idx);
        logic signed [lut_val_w(taps)-1:0] sum;
        sum = '0;
        for (int j = 0; j < taps; j++) begin
            if (idx[j]) begin
                sum = sum + COEFS[base_tap + j];
            end else begin
                sum = sum - COEFS[base_tap + j];
            end
        end
        return sum;
    endfunction

    // Table contents fixed at elaboration.
    for (genvar gi = 0; gi < 2**taps; gi++) begin : g_entry
        localparam logic signed [lut_val_w(taps)-1:0] ENTRY = entry(taps'(gi));
        assign lut[gi] = ENTRY;
    end

    assign value = lut[sel];

endmodule

/* rtl/da_pkg.sv */
package da_pkg;

    // Datapath sizes.
    localparam int NUM_TAPS = 8;
    localparam int SAMPLE_W = 8;
    localparam int COEF_W = 12;
    localparam int LUT_TAPS = 4;
    localparam int ACC_W = 24;
    localparam int BIT_CNT_W = $clog2(SAMPLE_W);

    // APB sizes.
    localparam int APB_ADDR_W = 8;
    localparam int APB_W = 32;
    localparam int LANES = APB_W / SAMPLE_W;

    // Mixed signs. Tap 1 holds the most negative value.
    localparam logic signed [COEF_W-1:0] COEFS [NUM_TAPS] = '{
        COEF_W'(731),
        COEF_W'(-2048),
        COEF_W'(2047),
        COEF_W'(-517),
        COEF_W'(96),
        COEF_W'(-1365),
        COEF_W'(13),
        COEF_W'(-7)
    };

    function automatic int coef_sum();
        int sum;
        sum = 0;
        for (int i = 0; i < NUM_TAPS; i++) begin
            sum += int'(COEFS[i]);
        end
        return sum;
    endfunction

    localparam int COEF_SUM = coef_sum();

    // Bank entry width with room for the sum of all its taps.
    function automatic int lut_val_w(int taps);
        return COEF_W + $clog2(taps + 1);
    endfunction

    // Register map.
    localparam logic [APB_ADDR_W-1:0] ADDR_CTRL = 8'h00;
    localparam logic [APB_ADDR_W-1:0] ADDR_SAMPLES_LO = 8'h04;
    localparam logic [APB_ADDR_W-1:0] ADDR_SAMPLES_HI = 8'h08;
    localparam logic [APB_ADDR_W-1:0] ADDR_RESULT = 8'h0C;

    // Bit 0 is start on write, busy on read.
    typedef struct packed {
        logic [APB_W-3:0] reserved;
        logic             done;
        logic             start_busy;
    } ctrl_view_t;

    typedef union packed {
        logic [LANES-1:0][SAMPLE_W-1:0] lane;
        ctrl_view_t                     ctrl;
    } apb_word_u;

endpackage

/* rtl/da_regs_decode.sv */
module da_regs_decode (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic [da_pkg::APB_ADDR_W-1:0]                 paddr,
    input  logic                                          psel,
    input  logic                                          penable,
    input  logic                                          pwrite,
    input  logic [da_pkg::APB_W-1:0]                      pwdata,
    input  logic                                          busy,
    input  logic                                          done,
    input  logic signed [da_pkg::APB_W-1:0]               result,
    output logic [da_pkg::APB_W-1:0]                      prdata,
    output logic                                          pready,
    output logic                                          pslverr,
    output logic                                          start,
    output logic [da_pkg::NUM_TAPS*da_pkg::SAMPLE_W-1:0]  samples
);
    import da_pkg::*;

    logic [NUM_TAPS-1:0][SAMPLE_W-1:0] samples_q;
    apb_word_u                         wr_word;
    apb_word_u                         rd_word;
    logic                              access;
    logic                              addr_ok;
    logic                              wr_result;

    assign access = psel && penable;
    assign wr_word = pwdata;

    // Zero wait states.
    assign pready = 1'b1;

    always_comb begin
        addr_ok = 1'b1;
        rd_word = '0;
        case (paddr)
            ADDR_CTRL: begin
                rd_word.ctrl.start_busy = busy;
                rd_word.ctrl.done = done;
            end
            ADDR_SAMPLES_LO: begin
                rd_word.lane = samples_q[LANES-1:0];
            end
            ADDR_SAMPLES_HI: begin
                rd_word.lane = samples_q[NUM_TAPS-1:LANES];
            end
            ADDR_RESULT: begin
                rd_word = result;
            end
            default: begin
                addr_ok = 1'b0;
            end
        endcase
    end

    // Result is read only.
    assign wr_result = pwrite && (paddr == ADDR_RESULT);

    assign pslverr = access && (!addr_ok || wr_result);

    assign prdata = (access && !pwrite) ? rd_word : '0;

    // A start while the engine runs is dropped.
    assign start = access && pwrite && (paddr == ADDR_CTRL)
                   && wr_word.ctrl.start_busy && !busy;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            samples_q <= '0;
        end else if (access && pwrite) begin
            case (paddr)
                ADDR_SAMPLES_LO: begin
                    samples_q[LANES-1:0] <= wr_word.lane;
                end
                ADDR_SAMPLES_HI: begin
                    samples_q[NUM_TAPS-1:LANES] <= wr_word.lane;
                end
                default: begin
                end
            endcase
        end
    end

    assign samples = samples_q;

endmodule

/* rtl/da_result.sv */
module da_result (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              start,
    input  logic signed [da_pkg::ACC_W-1:0]   acc,
    input  logic                              acc_valid,
    output logic signed [da_pkg::APB_W-1:0]   result,
    output logic                              done
);
    import da_pkg::*;

    logic signed [APB_W-1:0] acc_ext;
    logic signed [APB_W-1:0] diff;

    assign acc_ext = acc;

    // Accumulator holds twice the dot product plus the coefficient sum.
    assign diff = acc_ext - COEF_SUM;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result <= '0;
        end else if (acc_valid) begin
            // Always even, so the shift is exact.
            result <= diff >>> 1;
        end
    end

    // A new start wins over a finishing vector.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else if (start) begin
            done <= 1'b0;
        end else if (acc_valid) begin
            done <= 1'b1;
        end
    end

endmodule

/* rtl/da_top.sv */
module da_top (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [da_pkg::APB_ADDR_W-1:0]      paddr,
    input  logic                               psel,
    input  logic                               penable,
    input  logic                               pwrite,
    input  logic [da_pkg::APB_W-1:0]           pwdata,
    output logic [da_pkg::APB_W-1:0]           prdata,
    output logic                               pready,
    output logic                               pslverr
);
    import da_pkg::*;

    logic                          start;
    logic [NUM_TAPS*SAMPLE_W-1:0]  samples;
    logic                          busy;
    logic signed [ACC_W-1:0]       acc;
    logic                          acc_valid;
    logic signed [APB_W-1:0]       result;
    logic                          done;

    da_regs_decode u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .busy      (busy),
        .done      (done),
        .result    (result),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .start     (start),
        .samples   (samples)
    );

    da_bit_serial u_execute (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .samples   (samples),
        .busy      (busy),
        .acc       (acc),
        .acc_valid (acc_valid)
    );

    da_result u_result (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .acc       (acc),
        .acc_valid (acc_valid),
        .result    (result),
        .done      (done)
    );

endmodule

/* testbench/da_tb.sv */
module da_tb;
    import da_pkg::*;

    localparam int NUM_VECTORS = 200;
    localparam int CLK_PERIOD = 100;
    localparam int TIMEOUT_CYCLES = (NUM_VECTORS + 10) * 40;
    localparam int MAX_POLLS = 20;

    logic                          clk;
    logic                          rst_n;
    logic [APB_ADDR_W-1:0]         paddr;
    logic                          psel;
    logic                          penable;
    logic                          pwrite;
    logic [APB_W-1:0]              pwdata;
    logic [APB_W-1:0]              prdata;
    logic                          pready;
    logic                          pslverr;

    // Pending checks for the compare process.
    string                         chk_name [$];
    logic [APB_W-1:0]              chk_exp [$];
    logic [APB_W-1:0]              chk_act [$];

    logic [NUM_TAPS*SAMPLE_W-1:0]  model;
    int                            seed;
    int                            checks;
    int                            value_errors;
    int                            other_errors;
    int                            cycles;

    tb_clock_gen #(
        .period (CLK_PERIOD)
    ) u_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    da_top dut0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    // Plain dot product of signed samples and coefficients.
    function automatic int dot_ref(input logic [NUM_TAPS*SAMPLE_W-1:0] s);
        int sum;
        sum = 0;
        for (int i = 0; i < NUM_TAPS; i++) begin
            sum += int'($signed(s[i*SAMPLE_W +: SAMPLE_W])) * int'(COEFS[i]);
        end
        return sum;
    endfunction

    function automatic void queue_check(input string name, input logic [APB_W-1:0] exp,
                                        input logic [APB_W-1:0] act);
        chk_name.push_back(name);
        chk_exp.push_back(exp);
        chk_act.push_back(act);
    endfunction

    function automatic void print_counts();
        $display("Checks %0d, value errors %0d, other errors %0d",
                 checks, value_errors, other_errors);
    endfunction

    always @(negedge clk) begin : compare
        string            name;
        logic [APB_W-1:0] exp;
        logic [APB_W-1:0] act;
        while (chk_exp.size() > 0) begin
            name = chk_name.pop_front();
            exp = chk_exp.pop_front();
            act = chk_act.pop_front();
            checks++;
            assert (act === exp) else begin
                value_errors++;
                $display("ERR %s expected 0x%08h actual 0x%08h at %0t",
                         name, exp, act, $time);
            end
        end
    end

    // Setup edge, access edge, then back to idle.
    task automatic apb_xfer(input logic [APB_ADDR_W-1:0] addr, input logic is_write,
                            input logic [APB_W-1:0] wdata, input logic exp_err,
                            output logic [APB_W-1:0] rdata);
        @(posedge clk);
        paddr <= addr;
        pwrite <= is_write;
        pwdata <= wdata;
        psel <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        rdata = prdata;
        queue_check("pready", 32'(1'b1), 32'(pready));
        queue_check("pslverr", 32'(exp_err), 32'(pslverr));
        @(posedge clk);
        psel <= 1'b0;
        penable <= 1'b0;
        pwrite <= 1'b0;
    endtask

    task automatic reg_write(input logic [APB_ADDR_W-1:0] addr, input logic [APB_W-1:0] data);
        logic [APB_W-1:0] unused;
        apb_xfer(addr, 1'b1, data, 1'b0, unused);
        if (addr == ADDR_SAMPLES_LO) begin
            model[APB_W-1:0] = data;
        end else if (addr == ADDR_SAMPLES_HI) begin
            model[NUM_TAPS*SAMPLE_W-1:APB_W] = data;
        end
    endtask

    task automatic reg_read(input logic [APB_ADDR_W-1:0] addr, output logic [APB_W-1:0] data);
        apb_xfer(addr, 1'b0, '0, 1'b0, data);
    endtask

    task automatic read_check(input logic [APB_ADDR_W-1:0] addr, input string name,
                              input logic [APB_W-1:0] exp);
        logic [APB_W-1:0] data;
        reg_read(addr, data);
        queue_check(name, exp, data);
    endtask

    task automatic poll_done(input bit expect_busy);
        logic [APB_W-1:0] status;
        bit               seen;
        seen = 1'b0;
        for (int n = 0; n < MAX_POLLS && !seen; n++) begin
            reg_read(ADDR_CTRL, status);
            if (n == 0 && expect_busy) begin
                queue_check("ctrl", 32'h1, status);
            end
            seen = status[1];
        end
        assert (seen) else begin
            other_errors++;
            $display("Done flag was not seen within %0d status reads at %0t", MAX_POLLS, $time);
        end
        if (seen) begin
            queue_check("ctrl", 32'h2, status);
        end
    endtask

    task automatic run_vector(input logic [APB_W-1:0] lo, input logic [APB_W-1:0] hi);
        int expected;
        reg_write(ADDR_SAMPLES_LO, lo);
        reg_write(ADDR_SAMPLES_HI, hi);
        expected = dot_ref(model);
        reg_write(ADDR_CTRL, 32'h1);
        poll_done(1'b1);
        read_check(ADDR_RESULT, "result", expected);
    endtask

    task automatic check_reset_state();
        read_check(ADDR_CTRL, "ctrl", '0);
        read_check(ADDR_RESULT, "result", '0);
        read_check(ADDR_SAMPLES_LO, "samples_lo", '0);
        read_check(ADDR_SAMPLES_HI, "samples_hi", '0);
    endtask

    task automatic check_register_access();
        logic [APB_W-1:0] ctrl_before;
        logic [APB_W-1:0] result_before;
        logic [APB_W-1:0] junk;
        reg_write(ADDR_SAMPLES_LO, 32'h1234_5678);
        reg_write(ADDR_SAMPLES_HI, 32'h9abc_def0);
        read_check(ADDR_SAMPLES_LO, "samples_lo", 32'h1234_5678);
        read_check(ADDR_SAMPLES_HI, "samples_hi", 32'h9abc_def0);
        reg_read(ADDR_CTRL, ctrl_before);
        reg_read(ADDR_RESULT, result_before);
        // Unmapped writes and reads, then a write to the read-only result.
        apb_xfer(8'h10, 1'b1, 32'hffff_ffff, 1'b1, junk);
        apb_xfer(8'h06, 1'b1, 32'h0101_0101, 1'b1, junk);
        apb_xfer(8'h10, 1'b0, '0, 1'b1, junk);
        apb_xfer(ADDR_RESULT, 1'b1, 32'hdead_beef, 1'b1, junk);
        read_check(ADDR_SAMPLES_LO, "samples_lo", 32'h1234_5678);
        read_check(ADDR_SAMPLES_HI, "samples_hi", 32'h9abc_def0);
        read_check(ADDR_CTRL, "ctrl", ctrl_before);
        read_check(ADDR_RESULT, "result", result_before);
    endtask

    task automatic check_start_while_busy();
        int first_exp;
        int second_exp;
        reg_write(ADDR_SAMPLES_LO, 32'h7f01_80fe);
        reg_write(ADDR_SAMPLES_HI, 32'h3c80_c47f);
        first_exp = dot_ref(model);
        reg_write(ADDR_CTRL, 32'h1);
        // Both of these land before the engine finishes.
        reg_write(ADDR_SAMPLES_LO, 32'h8080_7f7f);
        second_exp = dot_ref(model);
        reg_write(ADDR_CTRL, 32'h1);
        poll_done(1'b0);
        read_check(ADDR_RESULT, "result", first_exp);
        repeat (3) begin
            read_check(ADDR_CTRL, "ctrl", 32'h2);
        end
        read_check(ADDR_RESULT, "result", first_exp);
        reg_write(ADDR_CTRL, 32'h1);
        poll_done(1'b1);
        read_check(ADDR_RESULT, "result", second_exp);
    endtask

    initial begin
        logic [APB_W-1:0] rnd_lo;
        logic [APB_W-1:0] rnd_hi;
        seed = 32'h030f600f;
        checks = 0;
        value_errors = 0;
        other_errors = 0;
        model = '0;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        wait (rst_n === 1'b1);
        check_reset_state();
        run_vector(32'h0000_0000, 32'h0000_0000);
        run_vector(32'h7f7f_7f7f, 32'h7f7f_7f7f);
        run_vector(32'h8080_8080, 32'h8080_8080);
        run_vector(32'h807f_807f, 32'h807f_807f);
        run_vector(32'h7f80_7f80, 32'h7f80_7f80);
        check_register_access();
        check_start_while_busy();
        for (int v = 0; v < NUM_VECTORS; v++) begin
            rnd_lo = $random(seed);
            rnd_hi = $random(seed);
            run_vector(rnd_lo, rnd_hi);
        end
        // Let the compare process drain.
        repeat (2) @(posedge clk);
        print_counts();
        if (value_errors == 0 && other_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        print_counts();
        $display("** FAIL **");
        $finish;
    end

endmodule

/* testbench/tb_clock_gen.sv */
module tb_clock_gen #(
    parameter int period = 100
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // Reset held low for three rising edges.
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule
